/* Bender.yml */
package:
  name: game_2048

export_include_dirs:
  - include

sources:
  - hdl/game_pkg.sv
  - hdl/board_orient.sv
  - hdl/row_merge.sv
  - hdl/board_status.sv
  - hdl/tile_spawner.sv
  - hdl/game_fsm.sv
  - hdl/game_2048_top.sv
  - target: simulation
    files:
      - dv/tb_game_2048.sv

/* compile.f */
+incdir+include
hdl/game_pkg.sv
hdl/board_orient.sv
hdl/row_merge.sv
hdl/board_status.sv
hdl/tile_spawner.sv
hdl/game_fsm.sv
hdl/game_2048_top.sv
dv/tb_game_2048.sv

/* dv/tb_game_2048.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module tb_game_2048;
    import game_pkg::*;

    localparam int N = `GRID_N;
    localparam int ACK_LIMIT = 50;
    localparam int SCORE_MAX = (1 << `SCORE_W) - 1;

    logic                clk;
    logic                reset;
    tile_t               goal;
    logic                move_req;
    logic [N-1:0]        move_dir;
    board_t              board;
    logic [`SCORE_W-1:0] score;
    game_status_e        status;
    logic                move_ack;

    integer seed;
    int     errors;
    int     tests;
    logic   check_armed;
    logic   expect_moved;
    board_t exp_board;
    board_t pre_board;
    logic [`SCORE_W-1:0] exp_score;
    game_status_e pre_status;
    logic   req_at_edge;
    logic   ack_prev;

    game_2048_top game_2048_top_inst (
        .clk      (clk),
        .reset    (reset),
        .goal     (goal),
        .move_req (move_req),
        .move_dir (move_dir),
        .board    (board),
        .score    (score),
        .status   (status),
        .move_ack (move_ack)
    );

    always #5 clk = ~clk;

    // reference move walks each line in move order and packs and merges it
    function automatic void ref_move(input board_t b, input logic [N-1:0] dir,
                                     output board_t nb, output int merges,
                                     output bit changed);
        int    rr [N];
        int    cc [N];
        tile_t line [N+1];
        tile_t outl [N];
        int    k;
        int    o;
        int    j;
        nb = b;
        merges = 0;
        for (int i = 0; i < N; i++) begin
            for (int p = 0; p < N; p++) begin
                rr[p] = i;
                cc[p] = p;
                if (dir == DIR_RIGHT) begin
                    cc[p] = N - 1 - p;
                end else if (dir == DIR_UP) begin
                    rr[p] = p;
                    cc[p] = i;
                end else if (dir == DIR_DOWN) begin
                    rr[p] = N - 1 - p;
                    cc[p] = i;
                end
            end
            for (int p = 0; p <= N; p++) begin
                line[p] = '0;
            end
            k = 0;
            for (int p = 0; p < N; p++) begin
                if (b[rr[p]][cc[p]] != 0) begin
                    line[k] = b[rr[p]][cc[p]];
                    k++;
                end
            end
            for (int p = 0; p < N; p++) begin
                outl[p] = '0;
            end
            o = 0;
            j = 0;
            while (j < N && line[j] != 0) begin
                if (line[j] == line[j+1]) begin
                    outl[o] = line[j] + 1;
                    merges++;
                    j += 2;
                end else begin
                    outl[o] = line[j];
                    j++;
                end
                o++;
            end
            for (int p = 0; p < N; p++) begin
                nb[rr[p]][cc[p]] = outl[p];
            end
        end
        changed = (nb != b);
    endfunction

    // win is checked before a full board with no equal neighbours
    function automatic game_status_e status_rule(input board_t b, input tile_t g);
        bit hit;
        bit full;
        bit pair;
        hit  = 0;
        full = 1;
        pair = 0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                hit  = hit | (b[i][j] == g);
                full = full & (b[i][j] != 0);
                if (j < N - 1 && b[i][j] == b[i][j+1]) pair = 1;
                if (i < N - 1 && b[i][j] == b[i+1][j]) pair = 1;
            end
        end
        if (hit) return STATUS_WIN;
        if (full && !pair) return STATUS_LOSE;
        return STATUS_ACTIVE;
    endfunction

    always @(posedge clk) begin
        req_at_edge <= move_req;
    end

    // compare on the falling edge where move_ack is first seen high
    always @(negedge clk) begin : compare_proc
        int spawned;
        int bad;
        if (move_ack === 1'b1 && ack_prev !== 1'b1) begin
            if (req_at_edge !== 1'b1) begin
                $display("move_ack rose while move_req was low");
                errors++;
            end
            if (check_armed) begin
                check_armed = 1'b0;
                spawned = 0;
                bad = 0;
                if (!expect_moved) begin
                    if (board !== pre_board) begin
                        $display("Fail board: got %h, expected %h", board, pre_board);
                        errors++;
                    end
                    if (status !== pre_status) begin
                        $display("Fail status: got %h, expected %h", status, pre_status);
                        errors++;
                    end
                end else begin
                    for (int i = 0; i < N; i++) begin
                        for (int j = 0; j < N; j++) begin
                            if (board[i][j] !== exp_board[i][j]) begin
                                if (exp_board[i][j] == 0 && (board[i][j] == 1 || board[i][j] == 2))
                                    spawned++;
                                else
                                    bad++;
                            end
                        end
                    end
                    if (bad != 0 || spawned != 1) begin
                        $display("Fail board: got %h, expected %h plus one new tile",
                                 board, exp_board);
                        errors++;
                    end
                end
                if (score !== exp_score) begin
                    $display("Fail score: got %h, expected %h", score, exp_score);
                    errors++;
                end
                if (status !== status_rule(board, goal)) begin
                    $display("Fail status: got %h, expected %h", status, status_rule(board, goal));
                    errors++;
                end
            end
        end
        ack_prev = move_ack;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        errors++;
        $display("tests %0d, errors %0d", tests, errors);
        $display("sim failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int start);
        tests++;
        $display("test %s: %0d errors", name, errors - start);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // one full handshake with the expected results set up before the request
    task automatic do_move(input logic [N-1:0] dir, input int hold);
        board_t nb;
        int     merges;
        bit     changed;
        int     waited;
        pre_board    = board;
        pre_status   = status;
        expect_moved = 1'b0;
        exp_score    = score;
        if (status == STATUS_ACTIVE && dir != 0 && (dir & (dir - 1)) == 0) begin
            ref_move(board, dir, nb, merges, changed);
            if (changed) begin
                expect_moved = 1'b1;
                exp_board    = nb;
                exp_score    = (int'(score) + merges > SCORE_MAX) ? SCORE_MAX : score + merges;
            end
        end
        check_armed = 1'b1;
        move_dir    = dir;
        move_req    = 1'b1;
        waited = 0;
        while (move_ack !== 1'b1 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (move_ack !== 1'b1) abort_run("timeout: no move_ack after move_req");
        repeat (hold) begin
            @(negedge clk);
            if (move_ack !== 1'b1) begin
                $display("move_ack fell while move_req was still high");
                errors++;
            end
        end
        move_req = 1'b0;
        waited = 0;
        while (move_ack !== 1'b0 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (move_ack !== 1'b0) abort_run("timeout: move_ack stayed high after move_req dropped");
    endtask

    task automatic start_game(input tile_t g);
        int tiles;
        goal = g;
        apply_reset();
        if (move_ack !== 1'b0) begin
            $display("Fail move_ack: got %h, expected 0", move_ack);
            errors++;
        end
        if (score !== 0) begin
            $display("Fail score: got %h, expected 0", score);
            errors++;
        end
        if (status !== STATUS_ACTIVE) begin
            $display("Fail status: got %h, expected %h", status, STATUS_ACTIVE);
            errors++;
        end
        // start, spawn and status check
        repeat (3) @(negedge clk);
        tiles = 0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (board[i][j] !== 0) begin
                    tiles++;
                    if (board[i][j] !== 1 && board[i][j] !== 2) tiles += 100;
                end
            end
        end
        if (tiles != 1) begin
            $display("Fail board: got %h, expected one tile of 1 or 2", board);
            errors++;
        end
    endtask

    initial begin
        int start;
        int moves;
        clk = 1'b0;
        reset = 1'b1;
        goal = 4'd15;
        move_req = 1'b0;
        move_dir = '0;
        seed = 30;
        errors = 0;
        tests = 0;
        check_armed = 1'b0;
        expect_moved = 1'b0;
        ack_prev = 1'b0;

        start = errors;
        start_game(4'd15);
        end_test("reset", start);

        start = errors;
        do_move(4'b0000, 0);
        do_move(4'b0011, 0);
        do_move(4'b1010, 0);
        end_test("illegal direction", start);

        start = errors;
        for (int m = 0; m < 200; m++) begin
            do_move(4'b0001 << ($unsigned($random(seed)) % N), $unsigned($random(seed)) % 3);
        end
        end_test("random moves", start);

        start = errors;
        for (int m = 0; m < 20; m++) begin
            do_move(4'b0001 << ($unsigned($random(seed)) % N), 1 + $unsigned($random(seed)) % 5);
        end
        end_test("handshake hold", start);

        // low goal so that a win comes quickly
        start = errors;
        start_game(4'd3);
        moves = 0;
        while (status != STATUS_WIN && moves < 1000) begin
            do_move(4'b0001 << ($unsigned($random(seed)) % N), 0);
            moves++;
        end
        if (status != STATUS_WIN) begin
            $display("status never reached WIN with goal 3");
            errors++;
        end
        end_test("win", start);

        start = errors;
        do_move(DIR_LEFT, 0);
        do_move(DIR_DOWN, 2);
        do_move(4'b0000, 0);
        do_move(DIR_RIGHT, 1);
        end_test("game over", start);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* hdl/board_orient.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module board_orient (
    input  game_pkg::dir_e   move_dir_q,
    input  game_pkg::board_t work_board,
    input  game_pkg::board_t merged_board,
    output game_pkg::board_t oriented,
    output game_pkg::board_t restored
);
    import game_pkg::*;

    localparam int N = `GRID_N;

    // every move becomes a move toward index 0
    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                case (move_dir_q)
                    DIR_RIGHT: oriented[i][j] = work_board[i][N-1-j];
                    // column i, top to bottom
                    DIR_UP:    oriented[i][j] = work_board[j][i];
                    // column i, bottom to top
                    DIR_DOWN:  oriented[i][j] = work_board[N-1-j][i];
                    default:   oriented[i][j] = work_board[i][j];
                endcase
            end
        end
    end

    // inverse mapping back to the board frame
    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                case (move_dir_q)
                    DIR_RIGHT: restored[i][j] = merged_board[i][N-1-j];
                    // transpose undoes itself
                    DIR_UP:    restored[i][j] = merged_board[j][i];
                    DIR_DOWN:  restored[i][j] = merged_board[j][N-1-i];
                    default:   restored[i][j] = merged_board[i][j];
                endcase
            end
        end
    end

endmodule

/* hdl/board_status.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module board_status (
    input  game_pkg::board_t board,
    input  game_pkg::tile_t  goal,
    output logic             goal_hit,
    output logic             no_moves
);
    import game_pkg::*;

    localparam int N = `GRID_N;

    logic full;
    logic pair_equal;

    always_comb begin
        goal_hit = 1'b0;
        full     = 1'b1;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (board[i][j] == goal) begin
                    goal_hit = 1'b1;
                end
                if (board[i][j] == '0) begin
                    full = 1'b0;
                end
            end
        end
    end

    // every horizontal and vertical neighbour pair
    always_comb begin
        pair_equal = 1'b0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N-1; j++) begin
                if (board[i][j] == board[i][j+1]) begin
                    pair_equal = 1'b1;
                end
                if (board[j][i] == board[j+1][i]) begin
                    pair_equal = 1'b1;
                end
            end
        end
    end

    assign no_moves = full && !pair_equal;

endmodule

/* hdl/game_2048_top.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module game_2048_top (
    input  logic                      clk,
    input  logic                      reset,
    input  game_pkg::tile_t           goal,
    input  logic                      move_req,
    input  logic [`GRID_N-1:0]        move_dir,
    output game_pkg::board_t          board,
    output logic [`SCORE_W-1:0]       score,
    output game_pkg::game_status_e    status,
    output logic                      move_ack
);
    import game_pkg::*;

    localparam int POS_W = $clog2(`GRID_N);

    dir_e                move_dir_q;
    board_t              work_board;
    board_t              oriented;
    board_t              merged_board;
    board_t              restored;
    logic [1:0]          merge_count [`GRID_N];
    logic [`GRID_N-1:0]  row_changed;
    logic                board_changed;
    logic [3:0]          merge_total;
    logic                goal_hit;
    logic                no_moves;
    logic [POS_W-1:0]    spawn_row;
    logic [POS_W-1:0]    spawn_col;
    tile_t               spawn_value;

    game_fsm game_fsm_inst (
        .clk           (clk),
        .reset         (reset),
        .goal_hit      (goal_hit),
        .no_moves      (no_moves),
        .move_req      (move_req),
        .move_dir      (move_dir),
        .oriented      (oriented),
        .merged_board  (merged_board),
        .restored      (restored),
        .board_changed (board_changed),
        .merge_total   (merge_total),
        .spawn_row     (spawn_row),
        .spawn_col     (spawn_col),
        .spawn_value   (spawn_value),
        .move_dir_q    (move_dir_q),
        .work_board    (work_board),
        .board         (board),
        .score         (score),
        .status        (status),
        .move_ack      (move_ack)
    );

    board_orient board_orient_inst (
        .move_dir_q   (move_dir_q),
        .work_board   (work_board),
        .merged_board (merged_board),
        .oriented     (oriented),
        .restored     (restored)
    );

    // one merger per working row
    for (genvar r = 0; r < `GRID_N; r++) begin : gen_rows
        row_merge row_merge_inst (
            .row_in      (oriented[r]),
            .merged_row  (merged_board[r]),
            .merge_count (merge_count[r]),
            .row_changed (row_changed[r])
        );
    end

    assign board_changed = |row_changed;

    always_comb begin
        merge_total = '0;
        for (int r = 0; r < `GRID_N; r++) begin
            merge_total = merge_total + 4'(merge_count[r]);
        end
    end

    board_status board_status_inst (
        .board    (board),
        .goal     (goal),
        .goal_hit (goal_hit),
        .no_moves (no_moves)
    );

    tile_spawner tile_spawner_inst (
        .clk         (clk),
        .reset       (reset),
        .board       (board),
        .spawn_row   (spawn_row),
        .spawn_col   (spawn_col),
        .spawn_value (spawn_value)
    );

endmodule

/* hdl/game_fsm.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module game_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          goal_hit,
    input  logic                          no_moves,
    input  logic                          move_req,
    input  logic [`GRID_N-1:0]            move_dir,
    input  game_pkg::board_t              oriented,
    input  game_pkg::board_t              merged_board,
    input  game_pkg::board_t              restored,
    input  logic                          board_changed,
    input  logic [3:0]                    merge_total,
    input  logic [$clog2(`GRID_N)-1:0]    spawn_row,
    input  logic [$clog2(`GRID_N)-1:0]    spawn_col,
    input  game_pkg::tile_t               spawn_value,
    output game_pkg::dir_e                move_dir_q,
    output game_pkg::board_t              work_board,
    output game_pkg::board_t              board,
    output logic [`SCORE_W-1:0]           score,
    output game_pkg::game_status_e        status,
    output logic                          move_ack
);
    import game_pkg::*;

    game_state_e         state;
    logic                dir_legal;
    logic                changed_q;
    logic [3:0]          merges_q;
    logic [`SCORE_W:0]   score_sum;
    logic [`SCORE_W-1:0] score_next;

    // only a single set bit is a real move
    always_comb begin
        case (move_dir)
            DIR_LEFT, DIR_UP, DIR_DOWN, DIR_RIGHT: dir_legal = 1'b1;
            default: dir_legal = 1'b0;
        endcase
    end

    // saturating score update
    assign score_sum  = {1'b0, score} + (`SCORE_W+1)'(merges_q);
    assign score_next = score_sum[`SCORE_W] ? '1 : score_sum[`SCORE_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_START;
            score      <= '0;
            status     <= STATUS_ACTIVE;
            move_ack   <= 1'b0;
            move_dir_q <= DIR_NONE;
        end else begin
            case (state)
                ST_START: begin
                    score <= '0;
                    state <= ST_SPAWN;
                end
                ST_SPAWN: begin
                    state <= ST_CHECK;
                end
                ST_WAIT_MOVE: begin
                    if (move_req) begin
                        if (dir_legal) begin
                            move_dir_q <= dir_e'(move_dir);
                            state      <= ST_ORIENT;
                        end else begin
                            // bad direction is acknowledged with no change
                            move_ack <= 1'b1;
                            state    <= ST_WAIT_RELEASE;
                        end
                    end
                end
                ST_ORIENT: begin
                    state <= ST_MERGE;
                end
                ST_MERGE: begin
                    state <= ST_RESTORE;
                end
                ST_RESTORE: begin
                    score <= score_next;
                    state <= changed_q ? ST_SPAWN : ST_CHECK;
                end
                ST_CHECK: begin
                    // no ack for the spawn after reset
                    move_ack <= move_req;
                    if (goal_hit) begin
                        status <= STATUS_WIN;
                        state  <= ST_WIN;
                    end else if (no_moves) begin
                        status <= STATUS_LOSE;
                        state  <= ST_LOSE;
                    end else begin
                        status <= STATUS_ACTIVE;
                        state  <= move_req ? ST_WAIT_RELEASE : ST_WAIT_MOVE;
                    end
                end
                ST_WAIT_RELEASE: begin
                    if (!move_req) begin
                        move_ack <= 1'b0;
                        state    <= ST_WAIT_MOVE;
                    end
                end
                ST_WIN, ST_LOSE: begin
                    // requests after game over are only acknowledged
                    move_ack <= move_req;
                end
                default: begin
                    state <= ST_START;
                end
            endcase
        end
    end

    // board and working copy
    always_ff @(posedge clk) begin
        case (state)
            ST_START: begin
                board <= '0;
            end
            ST_SPAWN: begin
                board[spawn_row][spawn_col] <= spawn_value;
            end
            ST_WAIT_MOVE: begin
                work_board <= board;
            end
            ST_ORIENT: begin
                changed_q <= board_changed;
                merges_q  <= merge_total;
            end
            ST_MERGE: begin
                // merged rows turned back into the board frame
                work_board <= restored;
            end
            ST_RESTORE: begin
                board <= work_board;
            end
            default: begin
            end
        endcase
    end

    // ack rises only in answer to a request
    assert property (@(posedge clk) disable iff (reset)
        !move_req && !move_ack |=> !move_ack);

    // game over is final until reset
    assert property (@(posedge clk) disable iff (reset)
        status != STATUS_ACTIVE |=> $stable(status));

endmodule

/* hdl/game_pkg.sv */
`include "game_defines.svh"

package game_pkg;

    // one cell holds the exponent of a power of two
    typedef logic [`TILE_W-1:0] tile_t;

    // index 0 is the cell a left move packs toward
    typedef tile_t [`GRID_N-1:0] row_t;

    // row 0 is the top row
    typedef row_t [`GRID_N-1:0] board_t;

    // one-hot move direction
    typedef enum logic [`GRID_N-1:0] {
        DIR_NONE  = 0,
        DIR_LEFT  = 1,
        DIR_UP    = 2,
        DIR_DOWN  = 4,
        DIR_RIGHT = 8
    } dir_e;

    typedef enum logic [3:0] {
        ST_START,
        ST_SPAWN,
        ST_WAIT_MOVE,
        ST_ORIENT,
        ST_MERGE,
        ST_RESTORE,
        ST_CHECK,
        ST_WAIT_RELEASE,
        ST_WIN,
        ST_LOSE
    } game_state_e;

    typedef enum logic [1:0] {
        STATUS_ACTIVE = 2'd0,
        STATUS_WIN    = 2'd1,
        STATUS_LOSE   = 2'd2
    } game_status_e;

endpackage

/* hdl/row_merge.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module row_merge (
    input  game_pkg::row_t row_in,
    output game_pkg::row_t merged_row,
    output logic [1:0]     merge_count,
    output logic           row_changed
);
    import game_pkg::*;

    localparam int N = `GRID_N;

    // one extra empty slot so the last cell has a neighbour
    tile_t packed_cells [N+1];

    // slide nonzero cells toward index 0
    always_comb begin
        int k;
        k = 0;
        for (int i = 0; i <= N; i++) begin
            packed_cells[i] = '0;
        end
        for (int i = 0; i < N; i++) begin
            if (row_in[i] != '0) begin
                packed_cells[k] = row_in[i];
                k = k + 1;
            end
        end
    end

    // merge equal neighbours once, scanning from index 0
    always_comb begin
        int  o;
        logic skip;
        o           = 0;
        skip        = 1'b0;
        merged_row  = '0;
        merge_count = '0;
        for (int i = 0; i < N; i++) begin
            if (skip) begin
                skip = 1'b0;
            end else if (packed_cells[i] != '0) begin
                if (packed_cells[i] == packed_cells[i+1]) begin
                    merged_row[o] = packed_cells[i] + 1'b1;
                    merge_count   = merge_count + 2'd1;
                    skip          = 1'b1;
                end else begin
                    merged_row[o] = packed_cells[i];
                end
                o = o + 1;
            end
        end
    end

    assign row_changed = (merged_row != row_in);

endmodule

/* hdl/tile_spawner.sv */
`timescale 1ns/1ps
`include "game_defines.svh"

module tile_spawner (
    input  logic                          clk,
    input  logic                          reset,
    input  game_pkg::board_t              board,
    output logic [$clog2(`GRID_N)-1:0]    spawn_row,
    output logic [$clog2(`GRID_N)-1:0]    spawn_col,
    output game_pkg::tile_t               spawn_value
);
    import game_pkg::*;

    localparam int N     = `GRID_N;
    localparam int POS_W = $clog2(`GRID_N);

    logic [`LFSR_W-1:0] lfsr;
    logic [POS_W-1:0]   cand_row;
    logic               found;
    logic               full;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= {lfsr[`LFSR_W-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign spawn_value = lfsr[2] ? tile_t'(2) : tile_t'(1);

    // scan rows from the random start row, wrapping around
    always_comb begin
        found     = 1'b0;
        cand_row  = lfsr[POS_W-1:0];
        spawn_row = lfsr[POS_W-1:0];
        spawn_col = '0;
        for (int k = 0; k < N; k++) begin
            if (!found) begin
                cand_row = POS_W'(lfsr[POS_W-1:0] + k);
                // downward scan leaves the lowest empty column
                for (int c = N-1; c >= 0; c--) begin
                    if (board[cand_row][c] == '0) begin
                        found     = 1'b1;
                        spawn_row = cand_row;
                        spawn_col = POS_W'(c);
                    end
                end
            end
        end
    end

    always_comb begin
        full = 1'b1;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (board[i][j] == '0) begin
                    full = 1'b0;
                end
            end
        end
    end

    // new tile never lands on an occupied cell
    assert property (@(posedge clk) disable iff (reset)
        !full |-> board[spawn_row][spawn_col] == '0);

endmodule

/* include/game_defines.svh */
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// board is GRID_N x GRID_N cells
`define GRID_N 4

// cell exponent width, 0 means empty
`define TILE_W 4

// score counter width
`define SCORE_W 12

// spawner LFSR
`define LFSR_W 8
`define LFSR_SEED 8'hA5

`endif
